// File: logic/img_pkg.sv
`default_nettype none

package img_pkg;

    // pixel bus width, as on the sensor
    parameter int pixel_w = 12;

    // histogram bin index, taken from the top pixel bits
    parameter int bin_w = 4;

    // bin counters and frame counter
    parameter int count_w = 32;

    // blanking, in clk cycles
    // fv rise to first lv rise
    parameter int front_porch = 6;
    // lv low after every line
    parameter int line_gap = 6;
    // fv low between frames
    parameter int frame_gap = 6;

    // test pattern select
    typedef enum logic [1:0] {
        // inverted frame-local pixel index
        pat_counter = 2'd0,
        // column times 16
        pat_ramp    = 2'd1,
        // highlight on every 4th row and column, shadow elsewhere
        pat_checker = 2'd2
    } pattern_e;

    // receiver bus tracking
    typedef enum logic [1:0] {
        idle     = 2'd0,
        in_frame = 2'd1,
        in_line  = 2'd2
    } rx_state_e;

endpackage

`default_nettype wire

// File: logic/pix_if.sv
`timescale 1ns/1ps
`default_nettype none

// pixel stream from frame receiver to histogram
// no back-pressure, one pixel per cycle at most
interface pix_if;

    // one cycle per pixel
    logic                        valid;
    logic [img_pkg::pixel_w-1:0] data;
    // first pixel of the frame, with valid
    logic                        sof;
    // last pixel of each line, with valid
    logic                        eol;
    // frame end strobe, valid low
    logic                        eof;

    // receiver side
    modport source (
        output valid,
        output data,
        output sof,
        output eol,
        output eof
    );

    // histogram side
    modport sink (
        input valid,
        input data,
        input sof,
        input eol,
        input eof
    );

endinterface

`default_nettype wire

// File: logic/img_source.sv
`timescale 1ns/1ps
`default_nettype none

module img_source #(
    parameter int img_width  = 32,
    parameter int img_height = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        enable,
    input  wire img_pkg::pattern_e           pattern,
    input  wire logic                        use_ext,
    input  wire logic                        ext_fv,
    input  wire logic                        ext_lv,
    input  wire logic [img_pkg::pixel_w-1:0] ext_d,
    output logic                             fv,
    output logic                             lv,
    output logic      [img_pkg::pixel_w-1:0] d
);

    localparam int pw = img_pkg::pixel_w;

    // last values of the pattern counters
    localparam logic [pw-1:0] last_col = pw'(img_width - 1);
    localparam logic [pw-1:0] last_row = pw'(img_height - 1);

    // blanking counter end values
    localparam logic [7:0] fp_last = 8'(img_pkg::front_porch - 1);
    localparam logic [7:0] lg_last = 8'(img_pkg::line_gap - 1);
    localparam logic [7:0] fg_last = 8'(img_pkg::frame_gap - 1);

    typedef enum logic [2:0] {
        s_idle  = 3'd0,
        s_porch = 3'd1,
        s_line  = 3'd2,
        s_gap   = 3'd3,
        s_fgap  = 3'd4
    } src_state_e;

    src_state_e        state;
    logic [7:0]        cnt;
    logic [pw-1:0]     row;
    logic [pw-1:0]     col;
    // frame-local pixel index, only its low bits matter
    logic [pw-1:0]     idx;
    img_pkg::pattern_e pat_q;
    logic              start;

    logic              gen_fv;
    logic              gen_lv;
    logic [pw-1:0]     gen_d;
    logic [pw-1:0]     pat_val;

    // registered external bus, same latency as the generator
    logic              ext_fv_q;
    logic              ext_lv_q;
    logic [pw-1:0]     ext_d_q;

    // new frame from idle, or straight out of the frame gap
    assign start = enable &
                   ((state == s_idle) | ((state == s_fgap) & (cnt == fg_last)));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= s_idle;
            cnt   <= '0;
            row   <= '0;
            col   <= '0;
            idx   <= '0;
            pat_q <= img_pkg::pat_counter;
        end else if (start) begin
            // pattern is fixed for the whole frame
            state <= s_porch;
            cnt   <= '0;
            row   <= '0;
            col   <= '0;
            idx   <= '0;
            pat_q <= pattern;
        end else begin
            case (state)
                s_porch: begin
                    if (cnt == fp_last) begin
                        state <= s_line;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_line: begin
                    // one pixel per cycle
                    idx <= idx + 1'b1;
                    if (col == last_col) begin
                        col   <= '0;
                        state <= s_gap;
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                s_gap: begin
                    if (cnt == lg_last) begin
                        cnt <= '0;
                        // last gap ends the frame
                        if (row == last_row) begin
                            state <= s_fgap;
                        end else begin
                            row   <= row + 1'b1;
                            state <= s_line;
                        end
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                s_fgap: begin
                    if (cnt == fg_last) begin
                        state <= s_idle;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                default: begin
                    state <= s_idle;
                end
            endcase
        end
    end

    // pattern value for the current row/col
    always_comb begin
        case (pat_q)
            img_pkg::pat_ramp: begin
                pat_val = {col[pw-5:0], 4'b0000};
            end
            img_pkg::pat_checker: begin
                pat_val = ((row[1:0] == 2'b00) && (col[1:0] == 2'b00)) ? '1 : '0;
            end
            default: begin
                pat_val = ~idx;
            end
        endcase
    end

    // fv spans porch, lines and line gaps
    assign gen_fv = (state == s_porch) | (state == s_line) | (state == s_gap);
    assign gen_lv = (state == s_line);
    // data parked at zero during blanking
    assign gen_d  = gen_lv ? pat_val : '0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ext_fv_q <= 1'b0;
            ext_lv_q <= 1'b0;
        end else begin
            ext_fv_q <= ext_fv;
            ext_lv_q <= ext_lv;
        end
    end

    always_ff @(posedge clk) begin
        ext_d_q <= ext_d;
    end

    // bus select
    assign fv = use_ext ? ext_fv_q : gen_fv;
    assign lv = use_ext ? ext_lv_q : gen_lv;
    assign d  = use_ext ? ext_d_q  : gen_d;

endmodule

`default_nettype wire

// File: logic/img_frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module img_frame_rx #(
    parameter int img_width  = 32,
    parameter int img_height = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        fv,
    input  wire logic                        lv,
    input  wire logic [img_pkg::pixel_w-1:0] d,
    pix_if.source                            pix,
    output logic      [img_pkg::count_w-1:0] frame_count,
    output logic                             geom_err
);

    localparam int cw = img_pkg::count_w;

    // expected geometry
    localparam logic [cw-1:0] exp_cols = cw'(img_width);
    localparam logic [cw-1:0] exp_rows = cw'(img_height);

    img_pkg::rx_state_e          state;
    logic                        bus_line;
    logic                        line_end;
    logic                        frame_end;
    logic [cw-1:0]               col_cnt;
    logic [cw-1:0]               row_cnt;
    logic [cw-1:0]               rows_now;
    logic                        line_bad;
    logic                        line_bad_now;

    // bus register stage
    logic                        valid_q;
    logic                        sof_q;
    logic                        eof_q;
    logic [img_pkg::pixel_w-1:0] d_q;

    // lv only counts inside a frame
    assign bus_line  = fv & lv;
    assign line_end  = (state == img_pkg::in_line) & ~bus_line;
    assign frame_end = (state != img_pkg::idle) & ~fv;

    // include a line that closes together with the frame
    assign rows_now     = line_end ? row_cnt + 1'b1 : row_cnt;
    assign line_bad_now = line_bad | (line_end & (col_cnt != exp_cols));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= img_pkg::idle;
        end else begin
            case (state)
                img_pkg::idle: begin
                    if (bus_line) begin
                        state <= img_pkg::in_line;
                    end else if (fv) begin
                        state <= img_pkg::in_frame;
                    end
                end
                img_pkg::in_frame: begin
                    if (!fv) begin
                        state <= img_pkg::idle;
                    end else if (lv) begin
                        state <= img_pkg::in_line;
                    end
                end
                img_pkg::in_line: begin
                    if (!fv) begin
                        state <= img_pkg::idle;
                    end else if (!lv) begin
                        state <= img_pkg::in_frame;
                    end
                end
                default: begin
                    state <= img_pkg::idle;
                end
            endcase
        end
    end

    // geometry counters and frame end checks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            line_bad    <= 1'b0;
            frame_count <= '0;
            geom_err    <= 1'b0;
        end else if (frame_end) begin
            col_cnt     <= '0;
            row_cnt     <= '0;
            line_bad    <= 1'b0;
            frame_count <= frame_count + 1'b1;
            // sticky until reset
            if (line_bad_now || (rows_now != exp_rows)) begin
                geom_err <= 1'b1;
            end
        end else if (bus_line) begin
            col_cnt <= col_cnt + 1'b1;
        end else if (line_end) begin
            col_cnt  <= '0;
            row_cnt  <= rows_now;
            line_bad <= line_bad_now;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
            sof_q   <= 1'b0;
            eof_q   <= 1'b0;
        end else begin
            valid_q <= bus_line;
            // first pixel of the first line
            sof_q   <= bus_line & (state != img_pkg::in_line) & (row_cnt == '0);
            // cycle after fv seen low
            eof_q   <= frame_end;
        end
    end

    always_ff @(posedge clk) begin
        d_q <= d;
    end

    assign pix.valid = valid_q;
    assign pix.data  = d_q;
    assign pix.sof   = sof_q;
    // registered pixel is the last one when the bus has left the line
    assign pix.eol   = valid_q & ~bus_line;
    assign pix.eof   = eof_q;

endmodule

`default_nettype wire

// File: logic/img_histogram.sv
`timescale 1ns/1ps
`default_nettype none

module img_histogram (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    pix_if.sink                              pix,
    input  wire logic [img_pkg::bin_w-1:0]   bin_sel,
    output logic      [img_pkg::count_w-1:0] bin_count,
    output logic                             frame_done
);

    localparam int cw    = img_pkg::count_w;
    localparam int bw    = img_pkg::bin_w;
    localparam int pw    = img_pkg::pixel_w;
    localparam int nbins = 2 ** bw;

    // bins of the frame in progress
    logic [cw-1:0] work [nbins];
    // bins of the last finished frame
    logic [cw-1:0] held [nbins];
    logic [bw-1:0] pix_bin;

    // brightness bin from the top pixel bits
    assign pix_bin = pix.data[pw-1 -: bw];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < nbins; i++) begin
                work[i] <= '0;
            end
        end else if (pix.sof) begin
            // fresh frame, sof pixel counts as the first hit
            for (int i = 0; i < nbins; i++) begin
                work[i] <= '0;
            end
            if (pix.valid) begin
                work[pix_bin] <= cw'(1);
            end
        end else if (pix.valid) begin
            work[pix_bin] <= work[pix_bin] + 1'b1;
        end
    end

    // snapshot at frame end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < nbins; i++) begin
                held[i] <= '0;
            end
        end else if (pix.eof) begin
            for (int i = 0; i < nbins; i++) begin
                held[i] <= work[i];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            frame_done <= 1'b0;
            bin_count  <= '0;
        end else begin
            // lines up with the new held bank
            frame_done <= pix.eof;
            // registered readout, one cycle after bin_sel
            bin_count  <= held[bin_sel];
        end
    end

endmodule

`default_nettype wire

// File: logic/img_capture_top.sv
`timescale 1ns/1ps
`default_nettype none

module img_capture_top #(
    parameter int img_width  = 32,
    parameter int img_height = 8
) (
    input  wire logic                        clk,
    input  wire logic                        rst_n,
    input  wire logic                        enable,
    input  wire img_pkg::pattern_e           pattern,
    input  wire logic                        use_ext,
    input  wire logic                        ext_fv,
    input  wire logic                        ext_lv,
    input  wire logic [img_pkg::pixel_w-1:0] ext_d,
    input  wire logic [img_pkg::bin_w-1:0]   bin_sel,
    output logic                             fv,
    output logic                             lv,
    output logic      [img_pkg::pixel_w-1:0] d,
    output logic      [img_pkg::count_w-1:0] frame_count,
    output logic                             geom_err,
    output logic      [img_pkg::count_w-1:0] bin_count,
    output logic                             frame_done
);

    // receiver to histogram
    pix_if pix ();

    // sensor model, or external bus pass-through
    img_source #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_source (
        .clk     (clk),
        .rst_n   (rst_n),
        .enable  (enable),
        .pattern (pattern),
        .use_ext (use_ext),
        .ext_fv  (ext_fv),
        .ext_lv  (ext_lv),
        .ext_d   (ext_d),
        .fv      (fv),
        .lv      (lv),
        .d       (d)
    );

    img_frame_rx #(
        .img_width  (img_width),
        .img_height (img_height)
    ) u_frame_rx (
        .clk         (clk),
        .rst_n       (rst_n),
        .fv          (fv),
        .lv          (lv),
        .d           (d),
        .pix         (pix.source),
        .frame_count (frame_count),
        .geom_err    (geom_err)
    );

    img_histogram u_histogram (
        .clk        (clk),
        .rst_n      (rst_n),
        .pix        (pix.sink),
        .bin_sel    (bin_sel),
        .bin_count  (bin_count),
        .frame_done (frame_done)
    );

endmodule

`default_nettype wire

// File: sim/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n
);

    // 10 ns period
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset held for 5 cycles, released just after an edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    end

endmodule

`default_nettype wire

// File: sim/tb_img_capture.sv
`timescale 1ns/1ps
`default_nettype none

module tb_img_capture;

    localparam int img_width  = 32;
    localparam int img_height = 8;
    localparam int pw         = img_pkg::pixel_w;
    localparam int bw         = img_pkg::bin_w;
    localparam int nbins      = 2 ** bw;

    // counter twice then ramp, checker, external and one more counter
    localparam int frames_run   = 6;
    localparam int frame_cycles = img_pkg::front_porch +
                                  img_height * (img_width + img_pkg::line_gap) +
                                  img_pkg::frame_gap;
    localparam int cycle_limit  = 4 * frames_run * frame_cycles;

    logic                        clk;
    logic                        rst_n;
    logic                        enable;
    img_pkg::pattern_e           pattern;
    logic                        use_ext;
    logic                        ext_fv;
    logic                        ext_lv;
    logic [pw-1:0]               ext_d;
    logic [bw-1:0]               bin_sel;
    logic                        fv;
    logic                        lv;
    logic [pw-1:0]               d;
    logic [img_pkg::count_w-1:0] frame_count;
    logic                        geom_err;
    logic [img_pkg::count_w-1:0] bin_count;
    logic                        frame_done;

    integer seed;
    int     cycle_cnt = 0;

    // bus monitor state
    logic              fv_prev = 1'b0;
    logic              lv_prev = 1'b0;
    img_pkg::pattern_e pat_prev;
    img_pkg::pattern_e frame_pat;
    logic              frame_ext;
    int                pix_idx;
    int                mon_col;
    int                mon_rows;
    int                fv_cyc;
    int                frames_started = 0;
    logic [pw-1:0]     ext_px;
    int                ext_cyc;

    // driven external pixels and the cycle each was driven in
    logic [pw-1:0]     ext_dq [$];
    int                ext_cq [$];
    // pattern code of each finished frame in bus order
    // -1 marks an external frame
    int                done_q [$];

    // histogram readout state
    int                done_cnt = 0;
    int                reads_done = 0;
    int                code;
    logic              err_expected = 1'b0;

    clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    img_capture_top #(
        .img_width  (img_width),
        .img_height (img_height)
    ) dut (
        .clk         (clk),
        .rst_n       (rst_n),
        .enable      (enable),
        .pattern     (pattern),
        .use_ext     (use_ext),
        .ext_fv      (ext_fv),
        .ext_lv      (ext_lv),
        .ext_d       (ext_d),
        .bin_sel     (bin_sel),
        .fv          (fv),
        .lv          (lv),
        .d           (d),
        .frame_count (frame_count),
        .geom_err    (geom_err),
        .bin_count   (bin_count),
        .frame_done  (frame_done)
    );

    // expected pixel at frame-local index idx
    function automatic logic [pw-1:0] expected_pixel(input img_pkg::pattern_e pat,
                                                     input int idx);
        int row;
        int col;
        row = idx / img_width;
        col = idx % img_width;
        case (pat)
            img_pkg::pat_ramp: return pw'(col * 16);
            img_pkg::pat_checker: return ((row % 4 == 0) && (col % 4 == 0)) ? '1 : '0;
            default: return pw'(~idx);
        endcase
    endfunction

    // pixels of one whole frame that land in bin
    function automatic int ref_bin_count(input img_pkg::pattern_e pat, input int bin);
        int n;
        logic [pw-1:0] px;
        n = 0;
        for (int i = 0; i < img_width * img_height; i++) begin
            px = expected_pixel(pat, i);
            if (int'(px[pw-1 -: bw]) == bin) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic string pat_name(input img_pkg::pattern_e pat);
        case (pat)
            img_pkg::pat_ramp: return "ramp";
            img_pkg::pat_checker: return "checker";
            default: return "counter";
        endcase
    endfunction

    task automatic abort_run(input string why);
        $display("ERROR: %s", why);
        $display("Result: FAILED");
        $fatal(1, "run aborted");
    endtask

    task automatic compare_values(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        if (expected !== actual) begin
            $display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
            $display("Result: FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    // lands 1 ns after the n-th rising edge
    task automatic wait_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #1;
        end
    endtask

    // one external frame with row short_row one pixel short
    task automatic drive_ext_frame(input int short_row);
        int n;
        wait_cycles(1);
        ext_fv = 1'b1;
        wait_cycles(img_pkg::front_porch);
        for (int r = 0; r < img_height; r++) begin
            n = (r == short_row) ? img_width - 1 : img_width;
            for (int c = 0; c < n; c++) begin
                ext_lv = 1'b1;
                ext_d  = pw'($random(seed));
                ext_dq.push_back(ext_d);
                ext_cq.push_back(cycle_cnt);
                wait_cycles(1);
            end
            ext_lv = 1'b0;
            ext_d  = '0;
            wait_cycles(img_pkg::line_gap);
        end
        ext_fv = 1'b0;
        wait_cycles(img_pkg::frame_gap);
    endtask

    // all sixteen held bins against the reference histogram
    task automatic read_bins(input img_pkg::pattern_e pat);
        logic [img_pkg::count_w-1:0] got [nbins];
        int sum;
        sum = 0;
        for (int b = 0; b < nbins; b++) begin
            @(posedge clk);
            #1;
            bin_sel = bw'(b);
            @(posedge clk);
            @(negedge clk);
            got[b] = bin_count;
            sum += int'(bin_count);
        end
        // total of what was read, before any single bin
        compare_values("bin sum", 32'(img_width * img_height), 32'(sum));
        for (int b = 0; b < nbins; b++) begin
            compare_values($sformatf("%s bin %0d", pat_name(pat), b),
                           32'(ref_bin_count(pat, b)), got[b]);
        end
    endtask

    // timeout
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= cycle_limit) begin
            abort_run("timeout, frames did not complete in time");
        end
    end

    // bus monitor sampled mid-cycle
    always @(negedge clk) begin
        if (rst_n) begin
            if (fv && !fv_prev) begin
                frames_started = frames_started + 1;
                // pattern as the source saw it at frame start
                frame_pat = pat_prev;
                frame_ext = use_ext;
                pix_idx   = 0;
                mon_col   = 0;
                mon_rows  = 0;
                fv_cyc    = cycle_cnt;
            end
            // fv rise to first lv rise
            if (lv && !lv_prev && (mon_rows == 0) && !frame_ext) begin
                compare_values("front porch", 32'(img_pkg::front_porch),
                               32'(cycle_cnt - fv_cyc));
            end
            if (lv && frame_ext) begin
                if (ext_dq.size() == 0) begin
                    abort_run("pixel on d with no external pixel driven");
                end
                ext_px  = ext_dq.pop_front();
                ext_cyc = ext_cq.pop_front();
                compare_values("ext pixel", 32'(ext_px), 32'(d));
                compare_values("ext latency", 32'(ext_cyc + 1), 32'(cycle_cnt));
            end else if (lv) begin
                compare_values($sformatf("%s pixel %0d", pat_name(frame_pat), pix_idx),
                               32'(expected_pixel(frame_pat, pix_idx)), 32'(d));
                pix_idx = pix_idx + 1;
                mon_col = mon_col + 1;
            end
            if (!lv && lv_prev) begin
                if (!frame_ext) begin
                    compare_values("line length", 32'(img_width), 32'(mon_col));
                end
                mon_col  = 0;
                mon_rows = mon_rows + 1;
            end
            if (!fv && fv_prev) begin
                if (!frame_ext) begin
                    compare_values("line count", 32'(img_height), 32'(mon_rows));
                end
                done_q.push_back(frame_ext ? -1 : int'(frame_pat));
            end
        end
        fv_prev  = fv;
        lv_prev  = lv;
        pat_prev = pattern;
    end

    // frame_done handling and histogram readout
    initial begin
        bin_sel = '0;
        forever begin
            @(negedge clk);
            if (rst_n && frame_done) begin
                done_cnt = done_cnt + 1;
                compare_values("frame count", 32'(done_cnt), frame_count);
                if (done_q.size() == 0) begin
                    abort_run("frame_done without a finished frame on the bus");
                end
                code = done_q.pop_front();
                // external frame carries the short line
                if (code < 0) begin
                    err_expected = 1'b1;
                end
                compare_values("geometry error", 32'(err_expected), 32'(geom_err));
                if (code >= 0) begin
                    read_bins(img_pkg::pattern_e'(code));
                end
                reads_done = reads_done + 1;
            end
        end
    end

    // stimulus
    initial begin
        enable  = 1'b0;
        pattern = img_pkg::pat_counter;
        use_ext = 1'b0;
        ext_fv  = 1'b0;
        ext_lv  = 1'b0;
        ext_d   = '0;
        seed    = 32'hbf68_152f;
        wait (rst_n === 1'b1);
        wait_cycles(1);
        enable = 1'b1;
        // ramp requested mid frame 2 and taken at frame 3
        wait (frames_started == 2);
        wait_cycles(100);
        pattern = img_pkg::pat_ramp;
        wait (frames_started == 3);
        wait_cycles(100);
        pattern = img_pkg::pat_checker;
        wait (frames_started == 4);
        wait_cycles(100);
        // frame 4 still runs to the end
        enable = 1'b0;
        wait (reads_done == 4);
        wait_cycles(4);
        use_ext = 1'b1;
        drive_ext_frame(3);
        wait (reads_done == 5);
        use_ext = 1'b0;
        pattern = img_pkg::pat_counter;
        enable  = 1'b1;
        wait (frames_started == 6);
        wait_cycles(20);
        enable = 1'b0;
        wait (reads_done == 6);
        compare_values("final frame count", 32'(frames_run), frame_count);
        compare_values("geometry error held", 32'd1, 32'(geom_err));
        $display("Result: PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: project.f
logic/img_pkg.sv
logic/pix_if.sv
logic/img_source.sv
logic/img_frame_rx.sv
logic/img_histogram.sv
logic/img_capture_top.sv
sim/clk_gen.sv
sim/tb_img_capture.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP      = tb_img_capture
FILELIST = project.f
BUILD    = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "Result: PASSED" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
